//--- logic/mario_consts.svh
`ifndef MARIO_CONSTS_SVH
`define MARIO_CONSTS_SVH

// 640x480 raster, one pixel per clock
`define H_VISIBLE     10'd640
`define H_SYNC_START  10'd656
`define H_SYNC_END    10'd752
`define H_TOTAL       10'd800
`define V_VISIBLE     10'd480
`define V_SYNC_START  10'd490
`define V_SYNC_END    10'd492
`define V_TOTAL       10'd525

// scene objects in world coordinates
`define GROUND_Y      10'd416
`define PIPE1_X       10'd100
`define PIPE2_X       10'd640
`define PIPE_Y        10'd354
`define PIPE_W        10'd64
`define PIPE_H        10'd62
`define CASTLE_X      10'd750
`define CASTLE_Y      10'd352
`define CASTLE_W      10'd88
`define CASTLE_H      10'd64
`define PLAYER_W      10'd26
`define PLAYER_H      10'd32
`define COIN_W        10'd16
`define COIN_H        10'd28
`define COIN1_X       10'd300
`define COIN1_Y       10'd300
`define COIN2_X       10'd900
`define COIN2_Y       10'd300

// flat palette, 4 bits per channel as r,g,b
`define RGB_SKY       12'h6AF
`define RGB_GROUND    12'hA52
`define RGB_PIPE      12'h0C0
`define RGB_CASTLE    12'h888
`define RGB_COIN      12'hFD0
`define RGB_MARIO     12'hF00
`define RGB_LUIGI     12'h2F4

// active-low segments, bit 7 is the decimal point
`define SEG_0         8'hC0
`define SEG_1         8'hF9
`define SEG_2         8'hA4

`endif

//--- logic/mario_pkg.sv
`default_nettype none

package mario_pkg;

    // screen or world coordinate, wraps at 1024
    typedef logic [9:0] coord_t;

    // player box top-left corner, world space
    typedef struct packed {
        coord_t x;
        coord_t y;
    } player_pos_t;

    // 12-bit colour
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // object owning a pixel
    typedef enum logic [2:0] {
        PIX_BLANK,
        PIX_SKY,
        PIX_GROUND,
        PIX_PIPE,
        PIX_CASTLE,
        PIX_COIN,
        PIX_LUIGI,
        PIX_MARIO
    } pixel_class_e;

endpackage

`default_nettype wire

//--- logic/raster_if.sv
`timescale 1ns/1ps
`default_nettype none

interface raster_if;

    // current raster point
    mario_pkg::coord_t draw_x;
    mario_pkg::coord_t draw_y;
    logic              visible;
    // active low
    logic              h_sync;
    logic              v_sync;
    // one cycle at line 480, column 0
    logic              frame_start;

    modport source (output draw_x, draw_y, visible, h_sync, v_sync, frame_start);
    modport sink   (input  draw_x, draw_y, visible, h_sync, v_sync, frame_start);

endinterface

`default_nettype wire

//--- logic/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "mario_consts.svh"

module vga_timing (
    input  wire       clk,
    input  wire       reset,
    raster_if.source  raster
);

    logic              h_last;
    logic              v_last;
    mario_pkg::coord_t next_x;
    mario_pkg::coord_t next_y;

    // ==========================================================
    // counter stepping
    // ==========================================================
    assign h_last = (raster.draw_x == `H_TOTAL - 10'd1);
    assign v_last = (raster.draw_y == `V_TOTAL - 10'd1);

    always_comb begin
        next_x = h_last ? '0 : raster.draw_x + 10'd1;
        next_y = raster.draw_y;
        // line advances only on column wrap
        if (h_last) begin
            next_y = v_last ? '0 : raster.draw_y + 10'd1;
        end
    end

    // ==========================================================
    // counters plus flags, all from the next point
    // ==========================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            raster.draw_x      <= '0;
            raster.draw_y      <= '0;
            // (0,0) is on screen
            raster.visible     <= 1'b1;
            raster.h_sync      <= 1'b1;
            raster.v_sync      <= 1'b1;
            raster.frame_start <= 1'b0;
        end else begin
            raster.draw_x      <= next_x;
            raster.draw_y      <= next_y;
            raster.visible     <= (next_x < `H_VISIBLE) && (next_y < `V_VISIBLE);
            // sync windows, low inside
            raster.h_sync      <= !((next_x >= `H_SYNC_START) && (next_x < `H_SYNC_END));
            raster.v_sync      <= !((next_y >= `V_SYNC_START) && (next_y < `V_SYNC_END));
            // first point below the picture
            raster.frame_start <= (next_x == '0) && (next_y == `V_VISIBLE);
        end
    end

endmodule

`default_nettype wire

//--- logic/coin_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mario_consts.svh"

module coin_tracker #(
    parameter mario_pkg::coord_t coin_x = `COIN1_X,
    parameter mario_pkg::coord_t coin_y = `COIN1_Y
) (
    input  wire                         clk,
    input  wire                         reset,
    raster_if.sink                      raster,
    input  wire mario_pkg::player_pos_t mario_pos,
    input  wire mario_pkg::player_pos_t luigi_pos,
    output logic                        eaten
);

    logic mario_hit;
    logic luigi_hit;

    // box test in world space, scroll plays no part
    // edges widened to 11 bits so right edges never wrap
    function automatic logic overlaps(input mario_pkg::player_pos_t p);
        logic [10:0] p_left;
        logic [10:0] p_right;
        logic [10:0] p_top;
        logic [10:0] p_bottom;
        logic [10:0] c_left;
        logic [10:0] c_right;
        logic [10:0] c_top;
        logic [10:0] c_bottom;
        p_left   = {1'b0, p.x};
        p_right  = {1'b0, p.x} + {1'b0, `PLAYER_W};
        p_top    = {1'b0, p.y};
        p_bottom = {1'b0, p.y} + {1'b0, `PLAYER_H};
        c_left   = {1'b0, coin_x};
        c_right  = {1'b0, coin_x} + {1'b0, `COIN_W};
        c_top    = {1'b0, coin_y};
        c_bottom = {1'b0, coin_y} + {1'b0, `COIN_H};
        return (p_left < c_right) && (c_left < p_right) &&
               (p_top < c_bottom) && (c_top < p_bottom);
    endfunction

    assign mario_hit = overlaps(mario_pos);
    assign luigi_hit = overlaps(luigi_pos);

    // sampled once per frame, sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            eaten <= 1'b0;
        end else if (raster.frame_start && (mario_hit || luigi_hit)) begin
            eaten <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/scene_mapper.sv
`timescale 1ns/1ps
`default_nettype none

`include "mario_consts.svh"

module scene_mapper (
    input  wire                         clk,
    input  wire                         reset,
    raster_if.sink                      raster,
    input  wire mario_pkg::coord_t      scroll,
    input  wire mario_pkg::player_pos_t mario_pos,
    input  wire mario_pkg::player_pos_t luigi_pos,
    input  wire [1:0]                   coin_eaten,
    output logic                        hs,
    output logic                        vs,
    output logic [3:0]                  red,
    output logic [3:0]                  green,
    output logic [3:0]                  blue
);

    mario_pkg::coord_t      world_x;
    mario_pkg::pixel_class_e pix_class;
    mario_pkg::rgb_t        pix_rgb;

    // offset from the box corner, mod 1024, must fall inside the size
    function automatic logic in_box(
        input mario_pkg::coord_t px,
        input mario_pkg::coord_t py,
        input mario_pkg::coord_t ox,
        input mario_pkg::coord_t oy,
        input mario_pkg::coord_t w,
        input mario_pkg::coord_t h
    );
        mario_pkg::coord_t dx;
        mario_pkg::coord_t dy;
        dx = px - ox;
        dy = py - oy;
        return (dx < w) && (dy < h);
    endfunction

    // screen column back into world space
    assign world_x = raster.draw_x + scroll;

    // ==========================================================
    // classify, highest priority first
    // ==========================================================
    always_comb begin
        if (!raster.visible) begin
            pix_class = mario_pkg::PIX_BLANK;
        end else if (in_box(world_x, raster.draw_y, mario_pos.x, mario_pos.y,
                            `PLAYER_W, `PLAYER_H)) begin
            pix_class = mario_pkg::PIX_MARIO;
        end else if (in_box(world_x, raster.draw_y, luigi_pos.x, luigi_pos.y,
                            `PLAYER_W, `PLAYER_H)) begin
            pix_class = mario_pkg::PIX_LUIGI;
        end else if ((!coin_eaten[0] && in_box(world_x, raster.draw_y, `COIN1_X, `COIN1_Y,
                                               `COIN_W, `COIN_H)) ||
                     (!coin_eaten[1] && in_box(world_x, raster.draw_y, `COIN2_X, `COIN2_Y,
                                               `COIN_W, `COIN_H))) begin
            pix_class = mario_pkg::PIX_COIN;
        end else if (in_box(world_x, raster.draw_y, `PIPE1_X, `PIPE_Y, `PIPE_W, `PIPE_H) ||
                     in_box(world_x, raster.draw_y, `PIPE2_X, `PIPE_Y, `PIPE_W, `PIPE_H)) begin
            pix_class = mario_pkg::PIX_PIPE;
        end else if (in_box(world_x, raster.draw_y, `CASTLE_X, `CASTLE_Y,
                            `CASTLE_W, `CASTLE_H)) begin
            pix_class = mario_pkg::PIX_CASTLE;
        end else if (raster.draw_y >= `GROUND_Y) begin
            // ground is fixed to the screen
            pix_class = mario_pkg::PIX_GROUND;
        end else begin
            pix_class = mario_pkg::PIX_SKY;
        end
    end

    // palette lookup
    always_comb begin
        case (pix_class)
            mario_pkg::PIX_SKY:    pix_rgb = `RGB_SKY;
            mario_pkg::PIX_GROUND: pix_rgb = `RGB_GROUND;
            mario_pkg::PIX_PIPE:   pix_rgb = `RGB_PIPE;
            mario_pkg::PIX_CASTLE: pix_rgb = `RGB_CASTLE;
            mario_pkg::PIX_COIN:   pix_rgb = `RGB_COIN;
            mario_pkg::PIX_LUIGI:  pix_rgb = `RGB_LUIGI;
            mario_pkg::PIX_MARIO:  pix_rgb = `RGB_MARIO;
            default:               pix_rgb = '0;
        endcase
    end

    // colour and syncs leave together, one clock late
    always_ff @(posedge clk) begin
        if (reset) begin
            hs    <= 1'b1;
            vs    <= 1'b1;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hs    <= raster.h_sync;
            vs    <= raster.v_sync;
            red   <= pix_rgb.red;
            green <= pix_rgb.green;
            blue  <= pix_rgb.blue;
        end
    end

endmodule

`default_nettype wire

//--- logic/score_display.sv
`timescale 1ns/1ps
`default_nettype none

`include "mario_consts.svh"

module score_display (
    input  wire [1:0]  coin_eaten,
    output logic [7:0] hex0,
    output logic [1:0] ledr
);

    logic [1:0] eaten_count;

    // coins eaten so far, 0 to 2
    assign eaten_count = {1'b0, coin_eaten[0]} + {1'b0, coin_eaten[1]};

    // single digit, decimal point dark
    always_comb begin
        case (eaten_count)
            2'd0:    hex0 = `SEG_0;
            2'd1:    hex0 = `SEG_1;
            default: hex0 = `SEG_2;
        endcase
    end

    // one led per coin
    assign ledr = coin_eaten;

endmodule

`default_nettype wire

//--- logic/mario_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mario_consts.svh"

module mario_top (
    input  wire                         clk,
    input  wire                         reset,
    input  wire mario_pkg::coord_t      scroll,
    input  wire mario_pkg::player_pos_t mario_pos,
    input  wire mario_pkg::player_pos_t luigi_pos,
    output logic                        hs,
    output logic                        vs,
    output logic [3:0]                  red,
    output logic [3:0]                  green,
    output logic [3:0]                  blue,
    output logic [7:0]                  hex0,
    output logic [1:0]                  ledr
);

    // bit per coin, 1 once eaten
    logic [1:0] coin_eaten;

    // ==========================================================
    // raster
    // ==========================================================
    raster_if raster ();

    vga_timing u_timing (
        .clk    (clk),
        .reset  (reset),
        .raster (raster.source)
    );

    // ==========================================================
    // coins
    // ==========================================================
    coin_tracker #(
        .coin_x (`COIN1_X),
        .coin_y (`COIN1_Y)
    ) u_coin1 (
        .clk       (clk),
        .reset     (reset),
        .raster    (raster.sink),
        .mario_pos (mario_pos),
        .luigi_pos (luigi_pos),
        .eaten     (coin_eaten[0])
    );

    coin_tracker #(
        .coin_x (`COIN2_X),
        .coin_y (`COIN2_Y)
    ) u_coin2 (
        .clk       (clk),
        .reset     (reset),
        .raster    (raster.sink),
        .mario_pos (mario_pos),
        .luigi_pos (luigi_pos),
        .eaten     (coin_eaten[1])
    );

    // ==========================================================
    // picture and score
    // ==========================================================
    scene_mapper u_scene (
        .clk        (clk),
        .reset      (reset),
        .raster     (raster.sink),
        .scroll     (scroll),
        .mario_pos  (mario_pos),
        .luigi_pos  (luigi_pos),
        .coin_eaten (coin_eaten),
        .hs         (hs),
        .vs         (vs),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    score_display u_score (
        .coin_eaten (coin_eaten),
        .hex0       (hex0),
        .ledr       (ledr)
    );

endmodule

`default_nettype wire

//--- dv/mario_model.svh
`ifndef MARIO_MODEL_SVH
`define MARIO_MODEL_SVH

// ==========================================================
// raster and scene layout, reference copy
// ==========================================================
localparam int M_H_VISIBLE    = 640;
localparam int M_H_SYNC_START = 656;
localparam int M_H_SYNC_END   = 752;
localparam int M_H_TOTAL      = 800;
localparam int M_V_VISIBLE    = 480;
localparam int M_V_SYNC_START = 490;
localparam int M_V_SYNC_END   = 492;
localparam int M_V_TOTAL      = 525;
localparam int M_GROUND_Y     = 416;
localparam int M_PIPE1_X      = 100;
localparam int M_PIPE2_X      = 640;
localparam int M_PIPE_Y       = 354;
localparam int M_PIPE_W       = 64;
localparam int M_PIPE_H       = 62;
localparam int M_CASTLE_X     = 750;
localparam int M_CASTLE_Y     = 352;
localparam int M_CASTLE_W     = 88;
localparam int M_CASTLE_H     = 64;
localparam int M_PLAYER_W     = 26;
localparam int M_PLAYER_H     = 32;
localparam int M_COIN_W       = 16;
localparam int M_COIN_H       = 28;
localparam int M_COIN1_X      = 300;
localparam int M_COIN1_Y      = 300;
localparam int M_COIN2_X      = 900;
localparam int M_COIN2_Y      = 300;

// palette and digit patterns
localparam mario_pkg::rgb_t M_RGB_SKY    = 12'h6AF;
localparam mario_pkg::rgb_t M_RGB_GROUND = 12'hA52;
localparam mario_pkg::rgb_t M_RGB_PIPE   = 12'h0C0;
localparam mario_pkg::rgb_t M_RGB_CASTLE = 12'h888;
localparam mario_pkg::rgb_t M_RGB_COIN   = 12'hFD0;
localparam mario_pkg::rgb_t M_RGB_MARIO  = 12'hF00;
localparam mario_pkg::rgb_t M_RGB_LUIGI  = 12'h2F4;
localparam logic [7:0]      M_SEG_0      = 8'hC0;
localparam logic [7:0]      M_SEG_1      = 8'hF9;
localparam logic [7:0]      M_SEG_2      = 8'hA4;

// sync levels, low inside the window
function automatic logic model_hs(input int x);
    return !(x >= M_H_SYNC_START && x < M_H_SYNC_END);
endfunction

function automatic logic model_vs(input int y);
    return !(y >= M_V_SYNC_START && y < M_V_SYNC_END);
endfunction

// object drawn at world x minus scroll, mod 1024
function automatic logic model_on_object(input int x, input int y, input int scroll,
                                         input int ox, input int oy, input int w,
                                         input int h);
    int left;
    int dx;
    left = (ox - scroll) & 1023;
    dx   = (x - left) & 1023;
    return (dx < w) && (y >= oy) && (y < oy + h);
endfunction

// ==========================================================
// pixel classification by priority
// ==========================================================
function automatic mario_pkg::pixel_class_e model_classify(
    input int x, input int y, input int scroll, input mario_pkg::player_pos_t m,
    input mario_pkg::player_pos_t l, input logic [1:0] eaten);
    if (x >= M_H_VISIBLE || y >= M_V_VISIBLE)
        return mario_pkg::PIX_BLANK;
    if (model_on_object(x, y, scroll, int'(m.x), int'(m.y), M_PLAYER_W, M_PLAYER_H))
        return mario_pkg::PIX_MARIO;
    if (model_on_object(x, y, scroll, int'(l.x), int'(l.y), M_PLAYER_W, M_PLAYER_H))
        return mario_pkg::PIX_LUIGI;
    if (!eaten[0] && model_on_object(x, y, scroll, M_COIN1_X, M_COIN1_Y, M_COIN_W, M_COIN_H))
        return mario_pkg::PIX_COIN;
    if (!eaten[1] && model_on_object(x, y, scroll, M_COIN2_X, M_COIN2_Y, M_COIN_W, M_COIN_H))
        return mario_pkg::PIX_COIN;
    if (model_on_object(x, y, scroll, M_PIPE1_X, M_PIPE_Y, M_PIPE_W, M_PIPE_H) ||
        model_on_object(x, y, scroll, M_PIPE2_X, M_PIPE_Y, M_PIPE_W, M_PIPE_H))
        return mario_pkg::PIX_PIPE;
    if (model_on_object(x, y, scroll, M_CASTLE_X, M_CASTLE_Y, M_CASTLE_W, M_CASTLE_H))
        return mario_pkg::PIX_CASTLE;
    // ground ignores scroll
    if (y >= M_GROUND_Y)
        return mario_pkg::PIX_GROUND;
    return mario_pkg::PIX_SKY;
endfunction

function automatic mario_pkg::rgb_t model_colour(input mario_pkg::pixel_class_e cls);
    case (cls)
        mario_pkg::PIX_SKY:    return M_RGB_SKY;
        mario_pkg::PIX_GROUND: return M_RGB_GROUND;
        mario_pkg::PIX_PIPE:   return M_RGB_PIPE;
        mario_pkg::PIX_CASTLE: return M_RGB_CASTLE;
        mario_pkg::PIX_COIN:   return M_RGB_COIN;
        mario_pkg::PIX_LUIGI:  return M_RGB_LUIGI;
        mario_pkg::PIX_MARIO:  return M_RGB_MARIO;
        default:               return 12'h000;
    endcase
endfunction

// ==========================================================
// coin rules and score digit
// ==========================================================
function automatic logic model_overlap(input mario_pkg::player_pos_t p, input int cx,
                                       input int cy);
    int px;
    int py;
    px = int'(p.x);
    py = int'(p.y);
    return (px < cx + M_COIN_W) && (cx < px + M_PLAYER_W) &&
           (py < cy + M_COIN_H) && (cy < py + M_PLAYER_H);
endfunction

// sticky flags after one frame strobe
function automatic logic [1:0] model_next_eaten(input logic [1:0] eaten,
                                                input mario_pkg::player_pos_t m,
                                                input mario_pkg::player_pos_t l);
    logic [1:0] next;
    next = eaten;
    if (model_overlap(m, M_COIN1_X, M_COIN1_Y) || model_overlap(l, M_COIN1_X, M_COIN1_Y))
        next[0] = 1'b1;
    if (model_overlap(m, M_COIN2_X, M_COIN2_Y) || model_overlap(l, M_COIN2_X, M_COIN2_Y))
        next[1] = 1'b1;
    return next;
endfunction

function automatic logic [7:0] model_segments(input logic [1:0] eaten);
    int n;
    n = int'(eaten[0]) + int'(eaten[1]);
    case (n)
        0:       return M_SEG_0;
        1:       return M_SEG_1;
        default: return M_SEG_2;
    endcase
endfunction

`endif

//--- dv/tb_mario.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mario;

    `include "mario_model.svh"

    localparam int CLK_HALF      = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int FRAME_TIMEOUT = 430000;
    localparam int MAX_PRINTS    = 20;
    localparam int NUM_FRAMES    = 11;
    // frame index at which reset is applied again
    localparam int RESET_FRAME   = 8;

    logic                   clk;
    logic                   reset;
    mario_pkg::coord_t      scroll;
    mario_pkg::player_pos_t mario_pos;
    mario_pkg::player_pos_t luigi_pos;
    logic                   hs;
    logic                   vs;
    logic [3:0]             red;
    logic [3:0]             green;
    logic [3:0]             blue;
    logic [7:0]             hex0;
    logic [1:0]             ledr;

    // tracked raster point of the outputs
    int         px;
    int         py;
    logic       locked;
    logic       prev_vs;
    logic       vs_fell;
    logic       timed_out;
    logic [1:0] exp_eaten;
    int         rgb_errors;
    int         sync_errors;
    int         score_errors;

    mario_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .scroll    (scroll),
        .mario_pos (mario_pos),
        .luigi_pos (luigi_pos),
        .hs        (hs),
        .vs        (vs),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hex0      (hex0),
        .ledr      (ledr)
    );

    always #CLK_HALF clk = ~clk;

    // ==========================================================
    // compare tasks
    // ==========================================================
    task automatic check_rgb(input int x, input int y, input mario_pkg::rgb_t got,
                             input mario_pkg::rgb_t exp);
        if (got !== exp) begin
            rgb_errors++;
            if (rgb_errors <= MAX_PRINTS)
                $display("FAIL @%0t: colour at (%0d,%0d) got %h expected %h",
                         $time, x, y, got, exp);
        end
    endtask

    task automatic check_sync(input string name, input int x, input int y,
                              input logic got, input logic exp);
        if (got !== exp) begin
            sync_errors++;
            if (sync_errors <= MAX_PRINTS)
                $display("FAIL @%0t: %s at (%0d,%0d) got %b expected %b",
                         $time, name, x, y, got, exp);
        end
    endtask

    task automatic check_score(input logic [7:0] got_hex, input logic [7:0] exp_hex,
                               input logic [1:0] got_led, input logic [1:0] exp_led);
        if (got_hex !== exp_hex || got_led !== exp_led) begin
            score_errors++;
            $display("FAIL @%0t: score hex0 %h ledr %b expected hex0 %h ledr %b",
                     $time, got_hex, got_led, exp_hex, exp_led);
        end
    endtask

    // ==========================================================
    // sampling and waits
    // ==========================================================
    // one falling edge, outputs are stable here
    task automatic sample_cycle();
        mario_pkg::rgb_t got_rgb;
        mario_pkg::rgb_t exp_rgb;
        @(negedge clk);
        got_rgb = {red, green, blue};
        vs_fell = prev_vs && !vs;
        prev_vs = vs;
        if (locked) begin
            px = px + 1;
            if (px == M_H_TOTAL) begin
                px = 0;
                py = (py + 1 == M_V_TOTAL) ? 0 : py + 1;
            end
        end else if (vs_fell) begin
            // vs fall marks column 0 of line 490
            locked = 1'b1;
            px = 0;
            py = M_V_SYNC_START;
        end
        if (locked) begin
            exp_rgb = model_colour(model_classify(px, py, int'(scroll), mario_pos,
                                                  luigi_pos, exp_eaten));
            check_sync("hs", px, py, hs, model_hs(px));
            check_sync("vs", px, py, vs, model_vs(py));
            check_rgb(px, py, got_rgb, exp_rgb);
        end
    endtask

    task automatic wait_vs_fall();
        int count;
        count = 0;
        vs_fell = 1'b0;
        while (!vs_fell && count < FRAME_TIMEOUT) begin
            sample_cycle();
            count++;
        end
        if (!vs_fell) begin
            timed_out = 1'b1;
            $display("timeout: no vs falling edge within %0d cycles", FRAME_TIMEOUT);
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        exp_eaten = 2'b00;
        locked = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        // outputs in their reset state
        check_sync("hs", 0, 0, hs, 1'b1);
        check_sync("vs", 0, 0, vs, 1'b1);
        check_rgb(0, 0, {red, green, blue}, 12'h000);
        check_score(hex0, M_SEG_0, ledr, 2'b00);
        prev_vs = vs;
        reset = 1'b0;
    endtask

    // ==========================================================
    // stimulus
    // ==========================================================
    function automatic mario_pkg::coord_t rand_coord(input int unsigned limit);
        int unsigned r;
        r = $urandom % limit;
        return r[9:0];
    endfunction

    // players away from both coins, scroll puts both coins on screen
    task automatic park_players();
        scroll      = 10'd290;
        mario_pos.x = 10'd400;
        mario_pos.y = 10'd384;
        luigi_pos.x = 10'd500;
        luigi_pos.y = 10'd384;
    endtask

    task automatic drive_frame(input int frame);
        int cx;
        int cy;
        int tx;
        int ty;
        mario_pkg::player_pos_t over;
        scroll    = rand_coord(1024);
        mario_pos = {rand_coord(1024), rand_coord(448)};
        luigi_pos = {rand_coord(1024), rand_coord(448)};
        // every third frame one player lands on a coin still there
        if (frame % 3 == 2 && exp_eaten != 2'b11) begin
            cx = exp_eaten[0] ? M_COIN2_X : M_COIN1_X;
            cy = exp_eaten[0] ? M_COIN2_Y : M_COIN1_Y;
            tx = cx + int'($urandom % 16) - 8;
            ty = cy + int'($urandom % 16) - 8;
            over.x = tx[9:0];
            over.y = ty[9:0];
            if (frame % 2 == 0)
                mario_pos = over;
            else
                luigi_pos = over;
        end
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        px           = 0;
        py           = 0;
        prev_vs      = 1'b1;
        vs_fell      = 1'b0;
        timed_out    = 1'b0;
        rgb_errors   = 0;
        sync_errors  = 0;
        score_errors = 0;
        park_players();
        void'($urandom(32'h83));
        apply_reset();
        for (int frame = 0; frame < NUM_FRAMES; frame++) begin
            if (frame == RESET_FRAME) begin
                park_players();
                apply_reset();
            end
            wait_vs_fall();
            if (timed_out)
                break;
            // frame strobe at line 480 already saw these positions
            exp_eaten = model_next_eaten(exp_eaten, mario_pos, luigi_pos);
            check_score(hex0, model_segments(exp_eaten), ledr, exp_eaten);
            if (frame != RESET_FRAME)
                drive_frame(frame);
        end
        $display("errors: colour %0d, sync %0d, score %0d, timeout %0d",
                 rgb_errors, sync_errors, score_errors, timed_out);
        if (!timed_out && rgb_errors + sync_errors + score_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
+incdir+dv
logic/mario_pkg.sv
logic/raster_if.sv
logic/vga_timing.sv
logic/coin_tracker.sv
logic/scene_mapper.sv
logic/score_display.sv
logic/mario_top.sv
dv/tb_mario.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ps --top-module tb_mario \
        -f filelist.f -o tb_mario_sim \
    && ./obj_dir/tb_mario_sim | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
